// File: hw/cpu_block_consts.svh
`ifndef CPU_BLOCK_CONSTS_SVH
`define CPU_BLOCK_CONSTS_SVH

// external memory bus geometry
`define ADDR_SIZE 8       // top bit selects the mirror half
`define DATA_SIZE 16

// cell array
`define CPU_QUANTITY 4    // keep a power of two, cpu_idx_t is log2 wide
`define WORDS_PER_CPU 8   // words copied by each cell

// dispatcher request queue
`define REQ_FIFO_DEPTH 4

`endif

// File: hw/cpu_block_pkg.sv
`default_nettype none
`include "cpu_block_consts.svh"

package cpu_block_pkg;

  // cell number, also the tag carried with every bus request
  typedef logic [$clog2(`CPU_QUANTITY)-1:0] cpu_idx_t;

  // what one cell asks of memory
  typedef struct packed {
    logic                  wr;     // 1 = write, 0 = read
    logic [`ADDR_SIZE-1:0] addr;
    logic [`DATA_SIZE-1:0] wdata;  // don't care on reads
  } cell_req_t;

  // fifo entry, the cell request plus who asked
  typedef struct packed {
    cell_req_t req;
    cpu_idx_t  cell_idx;           // routes read data back
  } bus_req_t;

endpackage

`default_nettype wire

// File: hw/mem_req_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_block_consts.svh"

// four-phase req/ack link, payload type set per instance
interface mem_req_if #(
  parameter type payload_t = logic
);

  logic                  req;      // held until ack seen
  logic                  ack;      // held until req dropped
  payload_t              payload;  // frozen while req is high
  logic [`DATA_SIZE-1:0] rdata;    // read word, valid with ack on cell links

  // side that starts a transfer
  modport requester (
    output req,
    output payload,
    input  ack,
    input  rdata
  );

  // side that answers it
  modport server (
    input  req,
    input  payload,
    output ack,
    output rdata
  );

endinterface

`default_nettype wire

// File: hw/cpu_cell.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_block_consts.svh"

// hard-wired copy job, src word + idx + 1 goes to the mirror half
module cpu_cell
  import cpu_block_pkg::*;
#(
  parameter cpu_idx_t CELL_IDX = '0
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start,   // one pulse kicks off the job
  mem_req_if.requester bus,
  output logic         done     // sticky until reset
);

  localparam int CNT_W = $clog2(`WORDS_PER_CPU);

  // first word of this cell's source region
  localparam logic [`ADDR_SIZE-1:0] BASE_ADDR =
    `ADDR_SIZE'(int'(CELL_IDX) * `WORDS_PER_CPU);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REQ,   // req up, waiting for ack with data
    ST_RD_WAIT,  // req down, waiting for ack to drop
    ST_WR_REQ,
    ST_WR_WAIT,
    ST_DONE
  } state_t;

  state_t                state;
  logic [CNT_W-1:0]      word_cnt;
  logic [`DATA_SIZE-1:0] rd_val;    // word fetched in the read phase
  logic [`ADDR_SIZE-1:0] src_addr;
  logic                  last_word;
  cell_req_t             req_pl;

  assign src_addr  = BASE_ADDR + `ADDR_SIZE'(word_cnt);
  assign last_word = (word_cnt == CNT_W'(`WORDS_PER_CPU - 1));

  // payload is a function of state and counter, both frozen while req is up
  always_comb begin
    req_pl.wr    = (state == ST_WR_REQ) || (state == ST_WR_WAIT);
    req_pl.addr  = req_pl.wr ? {1'b1, src_addr[`ADDR_SIZE-2:0]} : src_addr;
    req_pl.wdata = rd_val + `DATA_SIZE'(CELL_IDX) + `DATA_SIZE'(1);
  end

  assign bus.payload = req_pl;
  assign bus.req     = (state == ST_RD_REQ) || (state == ST_WR_REQ);
  assign done        = (state == ST_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      word_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE:    if (start) state <= ST_RD_REQ;
        ST_RD_REQ:  if (bus.ack) state <= ST_RD_WAIT;  // rdata latched below
        ST_RD_WAIT: if (!bus.ack) state <= ST_WR_REQ;
        ST_WR_REQ:  if (bus.ack) state <= ST_WR_WAIT;
        ST_WR_WAIT: begin
          if (!bus.ack) begin
            if (last_word) begin
              state <= ST_DONE;
            end else begin
              word_cnt <= word_cnt + 1'b1;
              state    <= ST_RD_REQ;
            end
          end
        end
        ST_DONE:    state <= ST_DONE;               // only reset leaves
        default:    state <= ST_IDLE;
      endcase
    end
  end

  // read data is only valid while ack is high
  always_ff @(posedge clk) begin
    if (state == ST_RD_REQ && bus.ack) rd_val <= bus.rdata;
  end

  // once raised, req waits for ack with the request untouched
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    bus.req && !bus.ack |=> bus.req && $stable(bus.payload));

endmodule

`default_nettype wire

// File: hw/dispatcher_of_cpus.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_block_consts.svh"

// round-robin pick among cells, tagged fifo toward the bus port
module dispatcher_of_cpus
  import cpu_block_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  mem_req_if.server             cells [`CPU_QUANTITY],
  mem_req_if.requester          bus,
  input  logic                  rsp_valid,   // one-cycle read return
  input  cpu_idx_t              rsp_idx,
  input  logic [`DATA_SIZE-1:0] rsp_data
);

  localparam int N     = `CPU_QUANTITY;
  localparam int DEPTH = `REQ_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic                  cell_req [N];
  cell_req_t             cell_pl  [N];
  logic [N-1:0]          ack_q;            // per-cell ack
  logic [N-1:0]          rd_busy;          // read queued, no data yet
  logic [`DATA_SIZE-1:0] rdata_q  [N];     // returned word, held for the cell
  logic [N-1:0]          pending;
  logic [N-1:0]          grant;            // one-hot
  cpu_idx_t              grant_idx;
  cpu_idx_t              rr_ptr;           // first cell looked at next time
  bus_req_t              push_data;
  bus_req_t              fifo_mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr, rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  fifo_full, fifo_empty;
  logic                  push, pop;
  logic                  out_req_q;        // req toward the port

  // unpack the interface array, indices must be constant
  for (genvar i = 0; i < N; i++) begin : g_cell
    assign cell_req[i]    = cells[i].req;
    assign cell_pl[i]     = cells[i].payload;
    assign cells[i].ack   = ack_q[i];
    assign cells[i].rdata = rdata_q[i];
    assign pending[i]     = cell_req[i] && !ack_q[i] && !rd_busy[i];
  end

  assign fifo_full  = (count == CNT_W'(DEPTH));
  assign fifo_empty = (count == '0);

  // scan from rr_ptr, nothing granted while the fifo is full
  always_comb begin
    cpu_idx_t cand;
    logic     found;
    grant     = '0;
    grant_idx = '0;
    found     = 1'b0;
    for (int k = 0; k < N; k++) begin
      cand = cpu_idx_t'((int'(rr_ptr) + k) % N);
      if (!found && pending[cand] && !fifo_full) begin
        found       = 1'b1;
        grant[cand] = 1'b1;
        grant_idx   = cand;
      end
    end
    push_data.req      = cell_pl[grant_idx];
    push_data.cell_idx = grant_idx;
  end

  assign push = |grant;
  assign pop  = out_req_q && bus.ack;   // port finished the head entry

  // per-cell ack, writes are posted and reads wait for data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q   <= '0;
      rd_busy <= '0;
      rr_ptr  <= '0;
    end else begin
      if (push) rr_ptr <= cpu_idx_t'((int'(grant_idx) + 1) % N);
      for (int i = 0; i < N; i++) begin
        if (grant[i]) begin
          if (cell_pl[i].wr) ack_q[i] <= 1'b1;
          else rd_busy[i] <= 1'b1;
        end else if (rsp_valid && rd_busy[i] && rsp_idx == cpu_idx_t'(i)) begin
          rd_busy[i] <= 1'b0;
          ack_q[i]   <= 1'b1;
        end else if (ack_q[i] && !cell_req[i]) begin
          ack_q[i] <= 1'b0;                // phase 4
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid) rdata_q[rsp_idx] <= rsp_data;
    if (push) fifo_mem[wr_ptr] <= push_data;
  end

  // fifo pointers and the bus-side handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_req_q <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
      if (pop) out_req_q <= 1'b0;
      else if (!out_req_q && !bus.ack && !fifo_empty) out_req_q <= 1'b1;
    end
  end

  assign bus.req     = out_req_q;
  assign bus.payload = fifo_mem[rd_ptr];   // rd_ptr moves only with req down

  a_fifo_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(DEPTH));
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant));

endmodule

`default_nettype wire

// File: hw/ext_mem_port.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_block_consts.svh"

// turns one fifo entry into one read_q/write_q cycle on the external bus
module ext_mem_port
  import cpu_block_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  mem_req_if.server             fifo,
  output logic [`ADDR_SIZE-1:0] addr_out,
  output logic [`DATA_SIZE-1:0] data_out,
  input  logic [`DATA_SIZE-1:0] data_in,
  output logic                  read_q,
  output logic                  write_q,
  input  logic                  read_dn,
  input  logic                  write_dn,
  output logic                  rsp_valid,
  output cpu_idx_t              rsp_idx,
  output logic [`DATA_SIZE-1:0] rsp_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,    // addr/data out, request line next
    ST_CYCLE,    // request line up, waiting for done
    ST_RELEASE   // request dropped, waiting for done to fall
  } state_t;

  state_t                state;
  bus_req_t              entry;        // accepted fifo head
  logic                  read_q_q, write_q_q;
  logic                  ack_q;        // toward the dispatcher
  logic                  rsp_valid_q;
  logic [`DATA_SIZE-1:0] rsp_data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      read_q_q    <= 1'b0;
      write_q_q   <= 1'b0;
      ack_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;                       // pulse
      if (ack_q && !fifo.req) ack_q <= 1'b0;     // dispatcher saw it
      case (state)
        ST_IDLE:  if (fifo.req && !ack_q) state <= ST_SETUP;
        ST_SETUP: begin
          read_q_q  <= !entry.req.wr;
          write_q_q <= entry.req.wr;
          state     <= ST_CYCLE;
        end
        ST_CYCLE: begin
          if ((read_q_q && read_dn) || (write_q_q && write_dn)) begin
            rsp_valid_q <= read_q_q;              // writes return nothing
            read_q_q    <= 1'b0;
            write_q_q   <= 1'b0;
            state       <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          if (!read_dn && !write_dn) begin
            ack_q <= 1'b1;                        // entry fully retired
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // payload regs
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && fifo.req && !ack_q) entry <= fifo.payload;
    if (state == ST_CYCLE && read_q_q && read_dn) rsp_data_q <= data_in;
  end

  assign addr_out   = entry.req.addr;
  assign data_out   = entry.req.wdata;
  assign read_q     = read_q_q;
  assign write_q    = write_q_q;
  assign rsp_valid  = rsp_valid_q;
  assign rsp_idx    = entry.cell_idx;   // held until the next accept
  assign rsp_data   = rsp_data_q;
  assign fifo.ack   = ack_q;
  assign fifo.rdata = rsp_data_q;

  a_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_q && write_q));
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (read_q || write_q) |=> !(read_q || write_q) || $stable(addr_out));

endmodule

`default_nettype wire

// File: hw/cpu_block.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_block_consts.svh"

// cells -> dispatcher -> external bus port
module cpu_block
  import cpu_block_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  output logic [`CPU_QUANTITY-1:0] done,
  output logic [`ADDR_SIZE-1:0]    addr_out,
  output logic [`DATA_SIZE-1:0]    data_out,
  input  logic [`DATA_SIZE-1:0]    data_in,
  output logic                     read_q,
  output logic                     write_q,
  input  logic                     read_dn,
  input  logic                     write_dn
);

  mem_req_if #(.payload_t(cell_req_t)) cell_link [`CPU_QUANTITY] ();
  mem_req_if #(.payload_t(bus_req_t))  bus_link ();

  // read return path, port back to dispatcher
  logic                  rsp_valid;
  cpu_idx_t              rsp_idx;
  logic [`DATA_SIZE-1:0] rsp_data;

  for (genvar i = 0; i < `CPU_QUANTITY; i++) begin : g_cpu_cell
    cpu_cell #(.CELL_IDX(cpu_idx_t'(i))) u_cell (
      .clk   (clk),
      .rst_n (rst_n),
      .start (start),
      .bus   (cell_link[i]),
      .done  (done[i])
    );
  end

  dispatcher_of_cpus u_dispatcher (
    .clk       (clk),
    .rst_n     (rst_n),
    .cells     (cell_link),
    .bus       (bus_link),
    .rsp_valid (rsp_valid),
    .rsp_idx   (rsp_idx),
    .rsp_data  (rsp_data)
  );

  ext_mem_port u_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .fifo      (bus_link),
    .addr_out  (addr_out),
    .data_out  (data_out),
    .data_in   (data_in),
    .read_q    (read_q),
    .write_q   (write_q),
    .read_dn   (read_dn),
    .write_dn  (write_dn),
    .rsp_valid (rsp_valid),
    .rsp_idx   (rsp_idx),
    .rsp_data  (rsp_data)
  );

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_block_consts.svh"

// external memory, each done line answers its request after a random wait
module tb_mem_model (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`ADDR_SIZE-1:0] addr_out,
  input  logic [`DATA_SIZE-1:0] data_out,   // write data from the dut
  output logic [`DATA_SIZE-1:0] data_in,    // read data back to the dut
  input  logic                  read_q,
  input  logic                  write_q,
  output logic                  read_dn,
  output logic                  write_dn
);

  logic [`DATA_SIZE-1:0] mem [2 ** `ADDR_SIZE];
  integer                seed;
  int                    delay;   // cycles left before done
  logic                  armed;   // wait drawn for the current request

  // random word at every address
  initial begin
    seed = 21;
    for (int a = 0; a < 2 ** `ADDR_SIZE; a++) mem[a] = `DATA_SIZE'($random(seed));
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      armed    <= 1'b0;
      delay    <= 0;
      data_in  <= '0;
    end else if (!read_q && !write_q) begin
      read_dn  <= 1'b0;    // phase 4, follows the request down
      write_dn <= 1'b0;
      armed    <= 1'b0;
    end else if (!read_dn && !write_dn) begin
      if (!armed) begin
        armed <= 1'b1;
        delay <= {$random(seed)} % 4;   // 0 to 3 extra cycles
      end else if (delay != 0) begin
        delay <= delay - 1;
      end else begin
        read_dn  <= read_q;
        write_dn <= write_q;
        if (read_q) data_in <= mem[addr_out];
        if (write_q) mem[addr_out] <= data_out;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_cpu_block.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_block_consts.svh"

// one full copy job of every cell against a memory with random latency
module tb_cpu_block;

  localparam int N_WORDS = `WORDS_PER_CPU;
  localparam int TOTAL   = `CPU_QUANTITY * N_WORDS;   // words copied overall
  localparam int MIRROR  = 2 ** (`ADDR_SIZE - 1);
  localparam int WDOG    = TOTAL * 2 * 10 + 1000;     // clocks, two bus cycles per word

  logic                     clk;
  logic                     rst_n;
  logic                     start;
  logic [`CPU_QUANTITY-1:0] done;
  logic [`ADDR_SIZE-1:0]    addr_out;
  logic [`DATA_SIZE-1:0]    data_out, data_in, exp_wdata;
  logic                     read_q, write_q, read_dn, write_dn;
  logic                     read_q_d, write_q_d;      // edge detect
  logic                     started;                  // low until start is driven
  logic                     saw_full;                 // fifo back-pressure reached
  int                       rd_cnt [2 ** `ADDR_SIZE];
  int                       wr_cnt [2 ** `ADDR_SIZE];
  int                       cell_wr [`CPU_QUANTITY];
  int                       total_wr, value_errs, proto_errs;

  cpu_block    u_dut (.*);
  tb_mem_model u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // preloaded source word + cell number + 1 (source is the mirror address minus its top bit)
  assign exp_wdata = u_mem.mem[{1'b0, addr_out[`ADDR_SIZE-2:0]}]
                   + `DATA_SIZE'(int'(addr_out[`ADDR_SIZE-2:0]) / N_WORDS) + 1'b1;

  // one count per bus cycle at the rising request line
  always @(posedge clk) begin
    read_q_d  <= read_q;
    write_q_d <= write_q;
    if (!rst_n) saw_full <= 1'b0;
    else if (u_dut.u_dispatcher.fifo_full) saw_full <= 1'b1;
    if (read_q && !read_q_d) rd_cnt[addr_out] <= rd_cnt[addr_out] + 1;
    if (write_q && !write_q_d) begin
      wr_cnt[addr_out] <= wr_cnt[addr_out] + 1;
      total_wr         <= total_wr + 1;
      if (addr_out[`ADDR_SIZE-1] && int'(addr_out[`ADDR_SIZE-2:0]) < TOTAL)
        cell_wr[int'(addr_out[`ADDR_SIZE-2:0]) / N_WORDS] <=
          cell_wr[int'(addr_out[`ADDR_SIZE-2:0]) / N_WORDS] + 1;
    end
  end

  a_copy_result: assert property (@(posedge clk) disable iff (!rst_n)
    write_q && !write_q_d && addr_out[`ADDR_SIZE-1] |-> data_out == exp_wdata)
    else begin
      value_errs++;
      $display("** Error: copy_result addr %0h expected %0h actual %0h",
               $sampled(addr_out), $sampled(exp_wdata), $sampled(data_out));
    end

  a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(read_q && write_q))
    else begin
      proto_errs++;
      $display("** Error: read_q and write_q were high in the same cycle");
    end

  // request held and address/data frozen until the done line is seen
  a_cycle_held: assert property (@(posedge clk) disable iff (!rst_n)
    (read_q && !read_dn) || (write_q && !write_dn) |=>
      $stable({read_q, write_q, addr_out, data_out}))
    else begin
      proto_errs++;
      $display("** Error: bus request dropped or addr_out/data_out moved before done");
    end

  // bus and done silent from time zero until start
  a_quiet_before_start: assert property (@(posedge clk)
    !started |-> !read_q && !write_q && done == '0)
    else begin
      proto_errs++;
      $display("** Error: bus or done active before start");
    end

  // last write is posted and may still sit in the fifo when done rises
  for (genvar i = 0; i < `CPU_QUANTITY; i++) begin : g_done_chk
    a_done_order: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(done[i]) |-> cell_wr[i] >= N_WORDS - 1)
      else begin
        value_errs++;
        $display("** Error: done_order cell %0d expected %0d writes actual %0d",
                 i, N_WORDS - 1, $sampled(cell_wr[i]));
      end
  end

  // every source read once, every mirror written once, nothing else touched
  task automatic check_totals();
    int exp_rd;
    int exp_wr;
    for (int a = 0; a < 2 ** `ADDR_SIZE; a++) begin
      exp_rd = (a < TOTAL) ? 1 : 0;
      exp_wr = (a >= MIRROR && a < MIRROR + TOTAL) ? 1 : 0;
      a_read_once: assert (rd_cnt[a] == exp_rd) else begin
        value_errs++;
        $display("** Error: read_count addr %0h expected %0d actual %0d", a, exp_rd, rd_cnt[a]);
      end
      a_write_once: assert (wr_cnt[a] == exp_wr) else begin
        value_errs++;
        $display("** Error: write_count addr %0h expected %0d actual %0d", a, exp_wr, wr_cnt[a]);
      end
    end
    a_all_done: assert (done == '1) else begin
      value_errs++;
      $display("** Error: all_done expected %0h actual %0h", {`CPU_QUANTITY{1'b1}}, done);
    end
    a_backpressure: assert (saw_full) else begin
      proto_errs++;
      $display("** Error: request fifo never filled, back-pressure not exercised");
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    start    = 1'b0;
    started  = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;
    repeat (4) @(negedge clk);          // bus must stay quiet here
    start   = 1'b1;
    started = 1'b1;
    @(negedge clk) start = 1'b0;
    while (total_wr < TOTAL) @(posedge clk);
    repeat (20) @(posedge clk);         // room for any stray extra cycle
    check_totals();
    $display("tb_cpu_block: %0d value errors, %0d protocol errors", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WDOG) @(posedge clk);
    $display("** Error: job not finished after %0d clocks", WDOG);
    $display("tb_cpu_block: %0d value errors, %0d protocol errors", value_errs, proto_errs);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
hw/cpu_block_pkg.sv
hw/mem_req_if.sv
hw/cpu_cell.sv
hw/dispatcher_of_cpus.sv
hw/ext_mem_port.sv
hw/cpu_block.sv
testbench/tb_mem_model.sv
testbench/tb_cpu_block.sv

// File: Makefile
# verilator build and run for the cpu block testbench
VERILATOR ?= verilator
TOP       ?= tb_cpu_block
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= RESULT: FAIL

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails on a crash or when the log holds the fail line
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; st=$$?; cat $(LOG); \
	test $$st -eq 0 && ! grep -q "$(FAIL_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
